// File: vlog.f
+incdir+.
cache_geom_pkg.sv
cache_types_pkg.sv
set_store.sv
way_match.sv
line_update.sv
update_sequencer.sv
line_cache.sv
line_cache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP = line_cache_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir
PASS_TEXT = NO ERRORS

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message stands on a line of its own
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: line_cache_tests.svh
`ifndef LINE_CACHE_TESTS_SVH
`define LINE_CACHE_TESTS_SVH

	// ========================================
	// bus drivers
	// ========================================

	// one read strobe lasting a single cycle
	task automatic read_line(input logic [adr_w-1:0] adr);
		@(negedge wclk);
		rd_stb = 1'b1;
		rd_adr = adr;
		@(negedge wclk);
		rd_stb = 1'b0;
	endtask

	// request held until up_ack, which must come two cycles after the strobe
	task automatic run_update(input update_op_t op, input logic [adr_w-1:0] adr,
			input logic [line_bytes-1:0] sel, input logic [line_w-1:0] dat);
		int cycles;
		@(negedge wclk);
		up_stb = 1'b1;
		up_op = op;
		up_adr = adr;
		up_sel = sel;
		up_dat = dat;
		cycles = 0;
		while (!up_ack && cycles < ack_limit) begin
			@(negedge wclk);
			cycles++;
		end
		if (!up_ack) begin
			report_failure($sformatf("no up_ack within %0d cycles of up_stb", ack_limit));
		end else if (cycles != 2) begin
			report_failure($sformatf("up_ack came %0d cycles after up_stb instead of 2", cycles));
		end
		@(negedge wclk);
		up_stb = 1'b0;
	endtask

	function automatic logic [line_w-1:0] random_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// the byte offset is random since it never takes part in a hit
	function automatic logic [adr_w-1:0] make_adr(input logic [high_w-1:0] high,
			input logic [set_bits-1:0] set);
		return {high, set, lo_bit'($urandom)};
	endfunction

	// few tags over few sets, so the mix sees hits, misses and evictions
	function automatic logic [adr_w-1:0] pool_adr();
		return make_adr(high_w'($urandom % 5), set_bits'($urandom % 3));
	endfunction

	function automatic update_op_t random_op();
		int unsigned pick;
		pick = $urandom % 3;
		if (pick == 0) begin
			return op_load;
		end else if (pick == 1) begin
			return op_write;
		end
		return op_invalidate;
	endfunction

	// ========================================
	// tests
	// ========================================

	task automatic test_after_reset();
		start_test("after_reset");
		repeat (20) read_line($urandom);
		finish_test();
	endtask

	task automatic test_load_read();
		logic [high_w-1:0] high;
		logic [set_bits-1:0] set;
		start_test("load_read");
		high = high_w'($urandom);
		set = set_bits'($urandom);
		run_update(op_load, make_adr(high, set), '0, random_line());
		read_line(make_adr(high, set));
		// same set, other tag
		read_line(make_adr(high ^ high_w'(1), set));
		finish_test();
	endtask

	// the fifth load pushes the first line out of way 3
	task automatic test_five_loads();
		logic [high_w-1:0] base;
		logic [set_bits-1:0] set;
		start_test("five_loads");
		base = high_w'($urandom);
		set = set_bits'($urandom);
		for (int i = 0; i < 5; i++) begin
			run_update(op_load, make_adr(base ^ high_w'(i), set), '0, random_line());
		end
		for (int i = 0; i < 5; i++) begin
			read_line(make_adr(base ^ high_w'(i), set));
		end
		finish_test();
	endtask

	task automatic test_write_merge();
		logic [high_w-1:0] high;
		logic [set_bits-1:0] set;
		start_test("write_merge");
		high = high_w'($urandom);
		set = set_bits'($urandom);
		run_update(op_load, make_adr(high, set), '0, random_line());
		run_update(op_write, make_adr(high, set), line_bytes'($urandom), random_line());
		read_line(make_adr(high, set));
		// a write to a line that is not there is acknowledged and dropped
		run_update(op_write, make_adr(high ^ high_w'(1), set), '1, random_line());
		read_line(make_adr(high ^ high_w'(1), set));
		read_line(make_adr(high, set));
		finish_test();
	endtask

	task automatic test_invalidate();
		logic [high_w-1:0] high;
		logic [set_bits-1:0] set;
		start_test("invalidate");
		high = high_w'($urandom);
		set = set_bits'($urandom);
		run_update(op_load, make_adr(high, set), '0, random_line());
		read_line(make_adr(high, set));
		run_update(op_invalidate, make_adr(high, set), '0, '0);
		read_line(make_adr(high, set));
		run_update(op_load, make_adr(high, set), '0, random_line());
		read_line(make_adr(high, set));
		finish_test();
	endtask

	// each update takes four cycles, so the reads span the whole update stream
	task automatic test_random_mix();
		start_test("random_mix");
		fork
			begin
				repeat (mix_updates) begin
					run_update(random_op(), pool_adr(), line_bytes'($urandom), random_line());
				end
			end
			begin
				repeat (mix_updates * 4) begin
					@(negedge wclk);
					rd_stb = 1'b1;
					rd_adr = pool_adr();
				end
				@(negedge wclk);
				rd_stb = 1'b0;
			end
		join
		finish_test();
	endtask

`endif

// File: line_cache_tb.sv
module line_cache_tb
	import cache_geom_pkg::*;
	import cache_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// run constants
	// ========================================

	localparam int clk_period = 4;
	localparam int reset_cycles = 8;
	localparam int unsigned rand_seed = 32'hb7f6_4fca;

	// longest wait for up_ack before the request is given up
	localparam int ack_limit = 8;

	// longest single operation: drive, ack wait and the drop cycle
	localparam int max_latency = ack_limit + 2;
	localparam int mix_updates = 60;

	// directed operations plus the settle time of each test, rounded up
	localparam int n_ops = 70 + mix_updates;
	localparam int watchdog_ns = (reset_cycles + n_ops * max_latency) * clk_period;

	// address bits above the set index
	localparam int high_w = adr_w - lo_bit - set_bits;

	logic wclk = 1'b0;
	logic rst;
	logic rd_stb;
	logic [adr_w-1:0] rd_adr;
	logic rd_ack;
	logic [line_w-1:0] rd_dat;
	logic up_stb;
	update_op_t up_op;
	logic [adr_w-1:0] up_adr;
	logic [line_bytes-1:0] up_sel;
	logic [line_w-1:0] up_dat;
	logic up_ack;

	// bookkeeping, check totals are folded in when a test finishes
	// while every error counts toward the total at once
	string test_name = "none";
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_run = 0;

	line_cache line_cache_i (
		.wclk(wclk),
		.rst(rst),
		.rd_stb(rd_stb),
		.rd_adr(rd_adr),
		.rd_ack(rd_ack),
		.rd_dat(rd_dat),
		.up_stb(up_stb),
		.up_op(up_op),
		.up_adr(up_adr),
		.up_sel(up_sel),
		.up_dat(up_dat),
		.up_ack(up_ack)
	);

	always #(clk_period / 2) wclk = ~wclk;

	// ========================================
	// reference model
	// ========================================

	// way 0 is the newest line of a set, as in the DUT
	logic [tag_w-1:0] m_tag [num_sets][num_ways];
	logic [line_w-1:0] m_dat [num_sets][num_ways];
	logic m_val [num_sets][num_ways];

	// returns the hit flag above the line data, a miss gives all zeros
	function automatic logic [line_w:0] ref_read(input logic [adr_w-1:0] adr);
		logic [set_bits-1:0] s;
		s = adr[lo_bit +: set_bits];
		for (int w = 0; w < num_ways; w++) begin
			if (m_val[s][w] && m_tag[s][w] == adr[adr_w-1:lo_bit]) begin
				return {1'b1, m_dat[s][w]};
			end
		end
		return '0;
	endfunction

	// applies one committed update to the model
	function automatic void ref_update(input update_op_t op, input logic [adr_w-1:0] adr,
			input logic [line_bytes-1:0] sel, input logic [line_w-1:0] dat);
		logic [set_bits-1:0] s;
		int hw;
		s = adr[lo_bit +: set_bits];
		hw = -1;
		// scan downward so the lowest hitting way is the one kept
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (m_val[s][w] && m_tag[s][w] == adr[adr_w-1:lo_bit]) begin
				hw = w;
			end
		end
		case (op)
			op_load: begin
				for (int w = num_ways - 1; w > 0; w--) begin
					m_tag[s][w] = m_tag[s][w-1];
					m_dat[s][w] = m_dat[s][w-1];
					m_val[s][w] = m_val[s][w-1];
				end
				m_tag[s][0] = adr[adr_w-1:lo_bit];
				m_dat[s][0] = dat;
				m_val[s][0] = 1'b1;
			end
			op_write: begin
				if (hw >= 0) begin
					for (int b = 0; b < line_bytes; b++) begin
						if (sel[b]) begin
							m_dat[s][hw][b*8 +: 8] = dat[b*8 +: 8];
						end
					end
				end
			end
			op_invalidate: begin
				if (hw >= 0) begin
					m_val[s][hw] = 1'b0;
				end
			end
			default: begin
			end
		endcase
	endfunction

	// ========================================
	// checking
	// ========================================

	task automatic compare_value(input string name, input string what,
			input logic [line_w-1:0] expected, input logic [line_w-1:0] actual);
		test_checks++;
		if (actual !== expected) begin
			$display("Error: %s %s expected %h actual %h", name, what, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("Failure in test %s: %s", test_name, msg);
		test_errors++;
		total_errors++;
	endtask

	// read expectations, stage 1 is the read sampled two edges ago
	logic st_valid [2];
	logic st_hit [2];
	logic [line_w-1:0] st_dat [2];
	string st_name [2];

	// high while the DUT sits in its commit cycle, the store write lands on the next edge
	logic commit_due = 1'b0;

	always @(negedge wclk) begin
		commit_due = up_ack;
	end

	// expectations are taken before the commit, so a read on the commit edge sees old data
	always @(posedge wclk) begin
		logic [line_w:0] r;
		st_valid[1] = st_valid[0];
		st_hit[1] = st_hit[0];
		st_dat[1] = st_dat[0];
		st_name[1] = st_name[0];
		st_valid[0] = 1'b0;
		if (!rst && rd_stb) begin
			r = ref_read(rd_adr);
			st_valid[0] = 1'b1;
			st_hit[0] = r[line_w];
			st_dat[0] = r[line_w-1:0];
			st_name[0] = test_name;
		end
		if (!rst && commit_due) begin
			ref_update(up_op, up_adr, up_sel, up_dat);
		end
	end

	// outputs settle after the rising edge and are checked half a cycle later
	always @(negedge wclk) begin
		if (!rst) begin
			if (st_valid[1]) begin
				compare_value(st_name[1], "rd_ack", line_w'(st_hit[1]), line_w'(rd_ack));
				compare_value(st_name[1], "rd_dat", st_dat[1], rd_dat);
			end else if (rd_ack) begin
				report_failure("rd_ack was raised with no read strobed two cycles before");
			end
		end
	end

	task automatic start_test(input string name);
		@(negedge wclk);
		#1;
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	// lets the last reads and commits drain before the counts are taken
	task automatic finish_test();
		repeat (4) @(negedge wclk);
		#1;
		$display("test %s: checks %0d, mismatches %0d", test_name, test_checks, test_errors);
		total_checks += test_checks;
		tests_run++;
	endtask

	`include "line_cache_tests.svh"

	// ========================================
	// main sequence
	// ========================================

	initial begin
		void'($urandom(rand_seed));
		rst = 1'b1;
		rd_stb = 1'b0;
		rd_adr = '0;
		up_stb = 1'b0;
		up_op = op_load;
		up_adr = '0;
		up_sel = '0;
		up_dat = '0;
		st_valid[0] = 1'b0;
		st_valid[1] = 1'b0;
		for (int s = 0; s < num_sets; s++) begin
			for (int w = 0; w < num_ways; w++) begin
				m_tag[s][w] = '0;
				m_dat[s][w] = '0;
				m_val[s][w] = 1'b0;
			end
		end
		repeat (reset_cycles) @(posedge wclk);
		@(negedge wclk);
		rst = 1'b0;

		test_after_reset();
		test_load_read();
		test_five_loads();
		test_write_merge();
		test_invalidate();
		test_random_mix();

		$display("tests %0d, checks %0d, mismatches %0d", tests_run, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// ends a run that has stalled somewhere
	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: line_cache.sv
// 4-way set-associative line cache, single clock
// read port hits in two cycles, update port runs through the sequencer
module line_cache
	import cache_geom_pkg::*;
	import cache_types_pkg::*;
(
	input  logic wclk,
	input  logic rst,
	input  logic rd_stb,
	input  logic [adr_w-1:0] rd_adr,
	output logic rd_ack,
	output logic [line_w-1:0] rd_dat,
	input  logic up_stb,
	input  update_op_t up_op,
	input  logic [adr_w-1:0] up_adr,
	input  logic [line_bytes-1:0] up_sel,
	input  logic [line_w-1:0] up_dat,
	output logic up_ack
);

	cache_set_t line_rd_a;
	cache_set_t line_rd_b;
	cache_set_t line_next;
	way_valid_t valid_rd_a;
	way_valid_t valid_rd_b;
	way_valid_t valid_next;

	logic rd_stb_r;
	logic [adr_w-1:0] rd_adr_r;
	logic rd_hit;
	logic [line_w-1:0] rd_hit_line;

	logic lookup;
	logic commit;
	logic up_hit;
	logic [way_idx_w-1:0] up_hit_way;
	logic up_hit_r;
	logic [way_idx_w-1:0] up_hit_way_r;

	update_sequencer seq_i (
		.wclk(wclk),
		.rst(rst),
		.up_stb(up_stb),
		.lookup(lookup),
		.commit(commit),
		.up_ack(up_ack)
	);

	// ========================================
	// storage
	// ========================================

	// port a serves the read path and port b the update lookup,
	// the update address is held steady by the requester
	set_store #(.payload_t(cache_set_t)) line_store_i (
		.wclk(wclk),
		.rst(rst),
		.we(commit),
		.wr_set(up_adr[lo_bit +: set_bits]),
		.wr_payload(line_next),
		.rd_set_a(rd_adr[lo_bit +: set_bits]),
		.rd_set_b(up_adr[lo_bit +: set_bits]),
		.rd_payload_a(line_rd_a),
		.rd_payload_b(line_rd_b)
	);

	set_store #(.payload_t(way_valid_t)) valid_store_i (
		.wclk(wclk),
		.rst(rst),
		.we(commit),
		.wr_set(up_adr[lo_bit +: set_bits]),
		.wr_payload(valid_next),
		.rd_set_a(rd_adr[lo_bit +: set_bits]),
		.rd_set_b(up_adr[lo_bit +: set_bits]),
		.rd_payload_a(valid_rd_a),
		.rd_payload_b(valid_rd_b)
	);

	// ========================================
	// read path
	// ========================================

	// address and strobe line up with the store output one edge later
	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_stb_r <= 1'b0;
		end else begin
			rd_stb_r <= rd_stb;
		end
	end

	always_ff @(posedge wclk) begin
		rd_adr_r <= rd_adr;
	end

	// only the hit flag and the line leave the read matcher
	way_match rd_match_i (
		.set_in(line_rd_a),
		.valid_in(valid_rd_a),
		.adr(rd_adr_r),
		.hit(rd_hit),
		.hit_way(),
		.hit_line(rd_hit_line)
	);

	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_ack <= 1'b0;
		end else begin
			rd_ack <= rd_stb_r & rd_hit;
		end
	end

	// data reads zero for a miss or when no read was strobed
	always_ff @(posedge wclk) begin
		rd_dat <= rd_stb_r ? rd_hit_line : '0;
	end

	// ========================================
	// update path
	// ========================================

	way_match up_match_i (
		.set_in(line_rd_b),
		.valid_in(valid_rd_b),
		.adr(up_adr),
		.hit(up_hit),
		.hit_way(up_hit_way),
		.hit_line()
	);

	// hit result is captured at the end of lookup and used by commit
	always_ff @(posedge wclk) begin
		if (rst) begin
			up_hit_r <= 1'b0;
			up_hit_way_r <= '0;
		end else if (lookup) begin
			up_hit_r <= up_hit;
			up_hit_way_r <= up_hit_way;
		end
	end

	line_update update_i (
		.op(up_op),
		.adr(up_adr),
		.sel(up_sel),
		.dat(up_dat),
		.set_in(line_rd_b),
		.valid_in(valid_rd_b),
		.hit(up_hit_r),
		.hit_way(up_hit_way_r),
		.set_out(line_next),
		.valid_out(valid_next)
	);

endmodule

// File: update_sequencer.sv
// steps each update request through lookup and commit
// idle samples the strobe, lookup reads the set, commit writes it back
module update_sequencer
	import cache_geom_pkg::*;
(
	input  logic wclk,
	input  logic rst,
	input  logic up_stb,
	output logic lookup,
	output logic commit,
	output logic up_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_commit
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;

	// ========================================
	// state machine
	// ========================================

	// the request is only sampled in idle, so the cycle after an
	// acknowledge never starts a new update
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (up_stb) begin
					state_next = st_lookup;
				end
			end
			st_lookup: begin
				state_next = st_commit;
			end
			st_commit: begin
				state_next = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge wclk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// lookup is the cycle in which the store read for the request is valid
	assign lookup = (state == st_lookup);

	// the store write and the acknowledge share the commit cycle
	assign commit = (state == st_commit);
	assign up_ack = (state == st_commit);

	// the requester sees exactly one acknowledge per request
	assert property (@(posedge wclk) disable iff (rst) up_ack |=> !up_ack)
		else $error("up_ack held for two cycles");

	// the stores are never written without a lookup just before
	assert property (@(posedge wclk) disable iff (rst) commit |-> $past(lookup))
		else $error("commit without a preceding lookup");

endmodule

// File: line_update.sv
// next contents of one set for a load, a write or an invalidate
// purely combinational, stored only when the sequencer commits
module line_update
	import cache_geom_pkg::*;
	import cache_types_pkg::*;
(
	input  update_op_t op,
	input  logic [adr_w-1:0] adr,
	input  logic [line_bytes-1:0] sel,
	input  logic [line_w-1:0] dat,
	input  cache_set_t set_in,
	input  way_valid_t valid_in,
	input  logic hit,
	input  logic [way_idx_w-1:0] hit_way,
	output cache_set_t set_out,
	output way_valid_t valid_out
);

	// ========================================
	// write merge
	// ========================================

	way_line_t hit_entry;
	way_line_t merged_entry;

	assign hit_entry = set_in[hit_way];

	// byte enables pick between the request data and the stored line,
	// the tag stays because the line was hit
	always_comb begin
		merged_entry = hit_entry;
		for (int b = 0; b < line_bytes; b++) begin
			if (sel[b]) begin
				merged_entry.data[b*8 +: 8] = dat[b*8 +: 8];
			end
		end
		// any write to a line marks it dirty, even with no byte enabled
		merged_entry.modified = 1'b1;
	end

	// ========================================
	// set contents
	// ========================================

	// everything defaults to the current contents, so a miss on write
	// or invalidate writes the set back unchanged
	always_comb begin
		set_out = set_in;
		valid_out = valid_in;
		case (op)
			op_load: begin
				// ways move up by one, the old top way falls out
				for (int w = num_ways - 1; w > 0; w--) begin
					set_out[w] = set_in[w-1];
				end
				set_out[0].tag = adr[adr_w-1:lo_bit];
				set_out[0].modified = 1'b0;
				set_out[0].data = dat;
				// valid bits follow their lines and the new line is valid
				valid_out = {valid_in[num_ways-2:0], 1'b1};
			end
			op_write: begin
				if (hit) begin
					set_out[hit_way] = merged_entry;
				end
			end
			op_invalidate: begin
				// the line data is left in place, only the valid bit drops
				if (hit) begin
					valid_out[hit_way] = 1'b0;
				end
			end
			default: begin
				set_out = set_in;
				valid_out = valid_in;
			end
		endcase
	end

endmodule

// File: way_match.sv
// tag compare for one set
// combinational, fed by a store read port and the address that was read
module way_match
	import cache_geom_pkg::*;
	import cache_types_pkg::*;
(
	input  cache_set_t set_in,
	input  way_valid_t valid_in,
	input  logic [adr_w-1:0] adr,
	output logic hit,
	output logic [way_idx_w-1:0] hit_way,
	output logic [line_w-1:0] hit_line
);

	logic [num_ways-1:0] way_hit;

	// a way hits only when it holds a valid line with the same tag
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = valid_in[w] && (set_in[w].tag == adr[adr_w-1:lo_bit]);
		end
	end

	// ========================================
	// way select
	// ========================================

	// walk from the top way down so the lowest hitting way wins
	always_comb begin
		hit_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit_way = way_idx_w'(w);
			end
		end
	end

	assign hit = |way_hit;

	// a miss returns an all-zero line
	assign hit_line = hit ? set_in[hit_way].data : '0;

	// the selected way must hold the requested tag and be valid
	always_comb begin
		if (hit) begin
			assert (valid_in[hit_way] && set_in[hit_way].tag == adr[adr_w-1:lo_bit])
				else $error("way_match picked way %0d which does not hit", hit_way);
		end
	end

endmodule

// File: set_store.sv
// small register array addressed by set number
// one write port and two read ports, each read port has one cycle of latency
module set_store
	import cache_geom_pkg::*;
	import cache_types_pkg::*;
#(
	parameter type payload_t = way_valid_t
) (
	input  logic wclk,
	input  logic rst,
	input  logic we,
	input  logic [set_bits-1:0] wr_set,
	input  payload_t wr_payload,
	input  logic [set_bits-1:0] rd_set_a,
	input  logic [set_bits-1:0] rd_set_b,
	output payload_t rd_payload_a,
	output payload_t rd_payload_b
);

	payload_t mem [num_sets];

	// reset empties every set so that no stale valid bit survives
	always_ff @(posedge wclk) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_set] <= wr_payload;
		end
	end

	// a read on the same edge as a write returns the old entry
	always_ff @(posedge wclk) begin
		rd_payload_a <= mem[rd_set_a];
		rd_payload_b <= mem[rd_set_b];
	end

	// the sequencer is back in idle one edge into reset,
	// so nothing may be committed while reset is held
	assert property (@(posedge wclk) rst |=> !we)
		else $error("set_store written during reset");

endmodule

// File: cache_types_pkg.sv
// record types shared by the stores, the matchers and the merge logic
package cache_types_pkg;

	import cache_geom_pkg::*;

	// ========================================
	// line storage
	// ========================================

	// one way of a set: tag, dirty mark and the line itself
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic modified;
		logic [line_w-1:0] data;
	} way_line_t;

	// all ways of one set, element 0 is the most recently loaded way
	typedef way_line_t [num_ways-1:0] cache_set_t;

	// one valid bit per way, same order as cache_set_t
	typedef logic [num_ways-1:0] way_valid_t;

	// ========================================
	// update port
	// ========================================

	// operation carried on up_op
	// load fills a line after a miss, write merges bytes into a hit,
	// invalidate drops the hitting way
	typedef enum logic [1:0] {
		op_load,
		op_write,
		op_invalidate
	} update_op_t;

endpackage

// File: cache_geom_pkg.sv
// sizes of the read cache
// everything that splits an address or sizes an array lives here
package cache_geom_pkg;

	// ========================================
	// address split
	// ========================================

	// width of a bus address
	localparam int adr_w = 32;

	// first address bit above the byte offset inside a line
	localparam int lo_bit = 4;

	// the set index sits directly above the byte offset
	localparam int set_bits = 6;
	localparam int num_sets = 64;

	// ========================================
	// ways and lines
	// ========================================

	localparam int num_ways = 4;
	localparam int way_idx_w = 2;
	localparam int line_bytes = 16;
	localparam int line_w = 128;

	// the tag keeps every bit from lo_bit upward, set index included,
	// so a tag compare alone decides a hit
	localparam int tag_w = adr_w - lo_bit;

endpackage
